// File: hdl/ifd_pkg.sv
// Shared widths, memory map, thread settings and types for the fetch and decode stage; import where needed

`default_nettype none

package ifd_pkg;

    // --------------------------------------------------
    // Datapath
    // --------------------------------------------------
    localparam int word_width = 36;
    localparam int addr_width = 10;

    // Instruction fields, packed opcode, D, A, B from the top bit down
    localparam int opcode_width    = 4;
    localparam int d_operand_width = 12;
    localparam int a_operand_width = 10;
    localparam int b_operand_width = 10;

    // Instruction memory, shared by all threads
    localparam int im_word_width = 36;
    localparam int im_depth      = 256;
    localparam int im_addr_width = 8;

    // Opcode decoder memory, one table per thread
    localparam int od_word_width   = 20;
    localparam int od_thread_depth = 16;
    localparam int od_addr_width   = 6;

    // --------------------------------------------------
    // Threads
    // --------------------------------------------------
    localparam int thread_count            = 4;
    localparam int thread_count_width      = 2;
    localparam int od_initial_thread_read  = 0;
    // Write side runs one thread ahead of the read side
    localparam int od_initial_thread_write = 1;

    // --------------------------------------------------
    // Write address map
    // --------------------------------------------------
    localparam int im_base_addr_write = 512;
    localparam int od_base_addr_write = 768;
    localparam int db_base_addr       = 1024;

    typedef enum logic [opcode_width-1:0] {
        op_add, op_sub, op_and, op_or,
        op_xor, op_xnor, op_nand, op_nor,
        op_shl, op_shr, op_mul, op_mhi,
        op_ld, op_st, op_jmp, op_nop
    } opcode_t;

    typedef logic [od_word_width-1:0]      alu_ctrl_t;
    typedef logic [thread_count_width-1:0] thread_t;

endpackage

`default_nettype wire

// File: hdl/write_window_decoder.sv
// Maps a raw write address onto one memory's window; instantiate once per memory-mapped block

`timescale 1ns/1ps
`default_nettype none

module write_window_decoder #(
    parameter int window_base  = 0,
    parameter int window_depth = 1
) (
    input  logic                          instruction_ok,
    input  logic [ifd_pkg::addr_width-1:0] raw_addr,
    output logic [ifd_pkg::addr_width-1:0] offset,
    output logic                          wren
);

    import ifd_pkg::*;

    // First address past the end of the window
    localparam int window_limit = window_base + window_depth;

    logic at_or_above_base;
    logic below_limit;
    logic in_window;

    // --------------------------------------------------
    // Offset translation
    // --------------------------------------------------

    // Zero-based offset into the window
    // Only meaningful while in_window is high
    assign offset = raw_addr - addr_width'(window_base);

    // --------------------------------------------------
    // Range check
    // --------------------------------------------------

    // Compare in integer space so an address below the base
    // cannot wrap around into the window
    assign at_or_above_base = (int'(raw_addr) >= window_base);
    assign below_limit      = (int'(raw_addr) <  window_limit);
    assign in_window        = at_or_above_base && below_limit;

    // Cancelled or annulled writes never reach the memory
    assign wren = instruction_ok && in_window;

endmodule

`default_nettype wire

// File: hdl/instruction_memory.sv
// Shared instruction RAM, one write port and one always-on registered read port

`timescale 1ns/1ps
`default_nettype none

module instruction_memory (
    input  logic                             clock,
    input  logic                             wren,
    input  logic [ifd_pkg::im_addr_width-1:0] write_addr,
    input  logic [ifd_pkg::im_word_width-1:0] write_data,
    input  logic [ifd_pkg::im_addr_width-1:0] read_addr,
    output logic [ifd_pkg::im_word_width-1:0] read_data
);

    import ifd_pkg::*;

    logic [im_word_width-1:0] ram [im_depth];

    // --------------------------------------------------
    // Write port
    // --------------------------------------------------

    always_ff @(posedge clock) begin
        if (wren) begin
            ram[write_addr] <= write_data;
        end
    end

    // --------------------------------------------------
    // Read port
    // --------------------------------------------------

    // The stage fetches every cycle, so there is no read enable
    // On a collision the array still holds the old word at this edge
    always_ff @(posedge clock) begin
        read_data <= ram[read_addr];
    end

endmodule

`default_nettype wire

// File: hdl/opcode_decoder_memory.sv
// Per-thread opcode to ALU control tables; each hardware thread gets its own mapping

`timescale 1ns/1ps
`default_nettype none

module opcode_decoder_memory (
    input  logic               clock,
    input  logic               arst_n,
    input  logic               wren,
    input  ifd_pkg::opcode_t   write_opcode,
    input  ifd_pkg::alu_ctrl_t write_data,
    input  ifd_pkg::opcode_t   read_opcode,
    output ifd_pkg::alu_ctrl_t alu_control
);

    import ifd_pkg::*;

    // One table of od_thread_depth entries per thread
    alu_ctrl_t tables [thread_count*od_thread_depth];

    thread_t read_thread;
    thread_t write_thread;

    logic [od_addr_width-1:0] read_index;
    logic [od_addr_width-1:0] write_index;

    // Round-robin step, wraps at thread_count
    function automatic thread_t next_thread(input thread_t current);
        thread_t last;
        last = thread_t'(thread_count - 1);
        if (current == last) begin
            return '0;
        end
        return current + thread_t'(1);
    endfunction

    // --------------------------------------------------
    // Thread counters
    // --------------------------------------------------

    // Both counters step every cycle, keeping a fixed distance
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            read_thread  <= thread_t'(od_initial_thread_read);
            write_thread <= thread_t'(od_initial_thread_write);
        end else begin
            read_thread  <= next_thread(read_thread);
            write_thread <= next_thread(write_thread);
        end
    end

    // Thread number selects the table, opcode the entry
    assign read_index  = {read_thread, read_opcode};
    assign write_index = {write_thread, write_opcode};

    // --------------------------------------------------
    // Table storage
    // --------------------------------------------------

    always_ff @(posedge clock) begin
        if (wren) begin
            tables[write_index] <= write_data;
        end
    end

    // Registered lookup, cleared so the stage outputs zero after reset
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            alu_control <= '0;
        end else begin
            alu_control <= tables[read_index];
        end
    end

endmodule

`default_nettype wire

// File: hdl/instruction_fetch_decode.sv
// Fetch and decode core: instruction RAM feeding the opcode tables, with operands aligned to the control word

`timescale 1ns/1ps
`default_nettype none

module instruction_fetch_decode (
    input  logic                                clock,
    input  logic                                arst_n,

    input  logic                                im_wren,
    input  logic [ifd_pkg::im_addr_width-1:0]   im_write_addr,
    input  logic [ifd_pkg::im_word_width-1:0]   im_write_data,
    input  logic [ifd_pkg::im_addr_width-1:0]   im_read_addr,

    input  logic                                od_wren,
    input  ifd_pkg::opcode_t                    od_write_addr,
    input  ifd_pkg::alu_ctrl_t                  od_write_data,

    output ifd_pkg::alu_ctrl_t                  alu_control,
    output logic [ifd_pkg::d_operand_width-1:0] da,
    output logic [ifd_pkg::d_operand_width-1:0] db,
    output logic [ifd_pkg::a_operand_width-1:0] a,
    output logic [ifd_pkg::b_operand_width-1:0] b
);

    import ifd_pkg::*;

    logic [im_word_width-1:0]   instruction;
    logic [opcode_width-1:0]    opcode_bits;
    logic [d_operand_width-1:0] d_field;
    logic [a_operand_width-1:0] a_field;
    logic [b_operand_width-1:0] b_field;
    logic [d_operand_width-1:0] d_rebased;

    // --------------------------------------------------
    // Fetch
    // --------------------------------------------------

    instruction_memory imem (
        .clock      (clock),
        .wren       (im_wren),
        .write_addr (im_write_addr),
        .write_data (im_write_data),
        .read_addr  (im_read_addr),
        .read_data  (instruction)
    );

    // Opcode on top, then D, A and B
    assign {opcode_bits, d_field, a_field, b_field} = instruction;

    // --------------------------------------------------
    // Decode
    // --------------------------------------------------

    opcode_decoder_memory odmem (
        .clock        (clock),
        .arst_n       (arst_n),
        .wren         (od_wren),
        .write_opcode (od_write_addr),
        .write_data   (od_write_data),
        .read_opcode  (opcode_t'(opcode_bits)),
        .alu_control  (alu_control)
    );

    // D seen from the B data-memory window, wraps modulo 2**12
    assign d_rebased = d_field - d_operand_width'(db_base_addr);

    // Operands wait one cycle for the table lookup
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            da <= '0;
            db <= '0;
            a  <= '0;
            b  <= '0;
        end else begin
            da <= d_field;
            db <= d_rebased;
            a  <= a_field;
            b  <= b_field;
        end
    end

endmodule

`default_nettype wire

// File: hdl/instruction_fetch_decode_mapped.sv
// Top of the fetch and decode stage, with both memories loaded through the processor's write port

`timescale 1ns/1ps
`default_nettype none

module instruction_fetch_decode_mapped (
    input  logic                                clock,
    input  logic                                arst_n,

    input  logic                                ior_previous,
    input  logic                                cancel_previous,

    input  logic [ifd_pkg::addr_width-1:0]      im_write_addr,
    input  logic [ifd_pkg::word_width-1:0]      im_write_data,
    input  logic [ifd_pkg::im_addr_width-1:0]   im_read_addr,

    input  logic [ifd_pkg::addr_width-1:0]      od_write_addr,
    input  logic [ifd_pkg::word_width-1:0]      od_write_data,

    output ifd_pkg::alu_ctrl_t                  alu_control,
    output logic [ifd_pkg::d_operand_width-1:0] da,
    output logic [ifd_pkg::d_operand_width-1:0] db,
    output logic [ifd_pkg::a_operand_width-1:0] a,
    output logic [ifd_pkg::b_operand_width-1:0] b
);

    import ifd_pkg::*;

    logic                  instruction_ok;
    logic [addr_width-1:0] im_offset;
    logic [addr_width-1:0] od_offset;
    logic                  im_wren;
    logic                  od_wren;

    // Only a real instruction that was not cancelled may write
    assign instruction_ok = ior_previous && !cancel_previous;

    // --------------------------------------------------
    // Write windows
    // --------------------------------------------------

    write_window_decoder #(
        .window_base  (im_base_addr_write),
        .window_depth (im_depth)
    ) decode_im (
        .instruction_ok (instruction_ok),
        .raw_addr       (im_write_addr),
        .offset         (im_offset),
        .wren           (im_wren)
    );

    write_window_decoder #(
        .window_base  (od_base_addr_write),
        .window_depth (od_thread_depth)
    ) decode_od (
        .instruction_ok (instruction_ok),
        .raw_addr       (od_write_addr),
        .offset         (od_offset),
        .wren           (od_wren)
    );

    // --------------------------------------------------
    // Fetch and decode
    // --------------------------------------------------

    // Upper offset and data bits fall outside each memory
    instruction_fetch_decode ifd (
        .clock         (clock),
        .arst_n        (arst_n),
        .im_wren       (im_wren),
        .im_write_addr (im_offset[im_addr_width-1:0]),
        .im_write_data (im_write_data[im_word_width-1:0]),
        .im_read_addr  (im_read_addr),
        .od_wren       (od_wren),
        .od_write_addr (opcode_t'(od_offset[opcode_width-1:0])),
        .od_write_data (od_write_data[od_word_width-1:0]),
        .alu_control   (alu_control),
        .da            (da),
        .db            (db),
        .a             (a),
        .b             (b)
    );

endmodule

`default_nettype wire

// File: tests/ifd_asserts.sv
// Concurrent checks on write gating and thread counters, bound into the mapped top level

`timescale 1ns/1ps
`default_nettype none

module ifd_asserts (
    input logic                         clock,
    input logic                         arst_n,
    input logic                         ior_previous,
    input logic                         cancel_previous,
    input logic                         im_wren,
    input logic                         od_wren,
    input ifd_pkg::thread_t             read_thread,
    input ifd_pkg::thread_t             write_thread
);

    import ifd_pkg::*;

    // Annulled or cancelled instructions never write either memory
    write_needs_valid_instruction: assert property (
        @(posedge clock) disable iff (!arst_n)
        (im_wren || od_wren) |-> (ior_previous && !cancel_previous)
    ) else $error("write enable raised without a valid, uncancelled instruction");

    // Read thread trails the write thread by one, modulo 4
    read_trails_write: assert property (
        @(posedge clock) disable iff (!arst_n)
        write_thread == thread_t'(read_thread + thread_t'(1))
    ) else $error("read and write thread counters out of step");

endmodule

bind instruction_fetch_decode_mapped ifd_asserts asserts0 (
    .clock           (clock),
    .arst_n          (arst_n),
    .ior_previous    (ior_previous),
    .cancel_previous (cancel_previous),
    .im_wren         (im_wren),
    .od_wren         (od_wren),
    .read_thread     (ifd.odmem.read_thread),
    .write_thread    (ifd.odmem.write_thread)
);

`default_nettype wire

// File: tests/ifd_tb.sv
// Testbench for the mapped fetch and decode stage; replays tests/ifd_trace.txt against a memory model

`timescale 1ns/1ps
`default_nettype none

module ifd_tb;

    import ifd_pkg::*;

    localparam trace_path = "tests/ifd_trace.txt";

    logic clock, arst_n, ior_previous, cancel_previous;
    logic [addr_width-1:0]      im_write_addr;
    logic [word_width-1:0]      im_write_data;
    logic [im_addr_width-1:0]   im_read_addr;
    logic [addr_width-1:0]      od_write_addr;
    logic [word_width-1:0]      od_write_data;
    alu_ctrl_t                  alu_control;
    logic [d_operand_width-1:0] da;
    logic [d_operand_width-1:0] db;
    logic [a_operand_width-1:0] a;
    logic [b_operand_width-1:0] b;

    // Reference memories, updated in trace order
    logic [im_word_width-1:0] im_model [im_depth];
    alu_ctrl_t                od_model [thread_count*od_thread_depth];

    // One entry per cycle, the oldest is due two edges after it was driven
    bit                       pending_valid [$];
    alu_ctrl_t                pending_alu [$];
    logic [im_word_width-1:0] pending_word [$];

    logic [31:0] lfsr_state;
    int          trace_fd, trace_total, cycle_index;

    instruction_fetch_decode_mapped dut0 (
        .clock (clock), .arst_n (arst_n),
        .ior_previous (ior_previous), .cancel_previous (cancel_previous),
        .im_write_addr (im_write_addr), .im_write_data (im_write_data),
        .im_read_addr (im_read_addr),
        .od_write_addr (od_write_addr), .od_write_data (od_write_data),
        .alu_control (alu_control), .da (da), .db (db), .a (a), .b (b)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // Trace length is known once reset is released
    initial begin
        wait (arst_n === 1'b1);
        #((trace_total + 20) * 8);
        $display("Timeout: the trace did not finish within %0d cycles", trace_total + 20);
        stop_with_failure();
    end

    task automatic stop_with_failure();
        $display("sim failed");
        $fatal(1);
    endtask

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------
    task automatic check_alu(input alu_ctrl_t expected, input alu_ctrl_t actual);
        if (actual !== expected) begin
            $display("** Error at %0t: alu_control expected %h actual %h", $time, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_d(input string name, input logic [d_operand_width-1:0] expected,
                           input logic [d_operand_width-1:0] actual);
        if (actual !== expected) begin
            $display("** Error at %0t: %s expected %h actual %h", $time, name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_a(input logic [a_operand_width-1:0] expected,
                           input logic [a_operand_width-1:0] actual);
        if (actual !== expected) begin
            $display("** Error at %0t: a expected %h actual %h", $time, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_b(input logic [b_operand_width-1:0] expected,
                           input logic [b_operand_width-1:0] actual);
        if (actual !== expected) begin
            $display("** Error at %0t: b expected %h actual %h", $time, expected, actual);
            stop_with_failure();
        end
    endtask

    // D seen from the B data-memory window, modulo 2**12
    function automatic logic [d_operand_width-1:0] rebase_d(input logic [d_operand_width-1:0] d);
        int span;
        span = 1 << d_operand_width;
        return d_operand_width'((int'(d) - db_base_addr + span) % span);
    endfunction

    // Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
    endfunction

    task automatic take_random(input int width, output logic [word_width-1:0] value);
        value = '0;
        for (int i = 0; i < width; i++) begin
            value = {value[word_width-2:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // Write port noise with ior_previous low, plus an unchecked fetch when asked
    task automatic drive_noise(input bit with_fetch);
        logic [word_width-1:0] r;
        ior_previous <= 1'b0;
        take_random(1, r);
        cancel_previous <= r[0];
        take_random(addr_width, r);
        im_write_addr <= r[addr_width-1:0];
        take_random(word_width, r);
        im_write_data <= r;
        take_random(addr_width, r);
        od_write_addr <= r[addr_width-1:0];
        take_random(word_width, r);
        od_write_data <= r;
        if (with_fetch) begin
            take_random(im_addr_width, r);
            im_read_addr <= r[im_addr_width-1:0];
        end
    endtask

    // --------------------------------------------------
    // Trace handling and reference model
    // --------------------------------------------------
    task automatic read_command(input int fd, output int found, output string text);
        string raw;
        found = 0;
        text  = "";
        while (!found && !$feof(fd)) begin
            raw = "";
            if ($fgets(raw, fd) != 0 && raw.len() > 0 && raw.getc(0) != "#"
                && raw.getc(0) != "\n") begin
                found = 1;
                text  = raw;
            end
        end
    endtask

    // A write driven at edge E lands at E+1 in write thread (E+1) mod 4
    task automatic model_write(input logic ok, input logic [addr_width-1:0] im_addr,
                               input logic [word_width-1:0] im_data,
                               input logic [addr_width-1:0] od_addr,
                               input logic [word_width-1:0] od_data);
        int im_offset, od_offset, thread;
        thread    = (cycle_index + 1) % thread_count;
        im_offset = int'(im_addr) - im_base_addr_write;
        od_offset = int'(od_addr) - od_base_addr_write;
        if (ok && im_offset >= 0 && im_offset < im_depth)
            im_model[im_offset] = im_data[im_word_width-1:0];
        if (ok && od_offset >= 0 && od_offset < od_thread_depth)
            od_model[thread * od_thread_depth + od_offset] = od_data[od_word_width-1:0];
    endtask

    task automatic run_command(input string text);
        string kind;
        logic [3:0] ior_flag, cancel_flag;
        logic [addr_width-1:0] im_addr, od_addr;
        logic [word_width-1:0] im_data, od_data, trace_word, word;
        logic [im_addr_width-1:0] fetch_addr;
        alu_ctrl_t trace_alu, control;
        int thread;
        void'($sscanf(text, "%s", kind));
        if (kind == "w" && $sscanf(text, "%s %h %h %h %h %h %h", kind, ior_flag, cancel_flag,
                                   im_addr, im_data, od_addr, od_data) == 7) begin
            drive_noise(1'b1);
            ior_previous    <= ior_flag[0];
            cancel_previous <= cancel_flag[0];
            im_write_addr   <= im_addr;
            im_write_data   <= im_data;
            od_write_addr   <= od_addr;
            od_write_data   <= od_data;
            model_write(ior_flag[0] && !cancel_flag[0], im_addr, im_data, od_addr, od_data);
            pending_valid.push_back(1'b0);
        end else if (kind == "f" && $sscanf(text, "%s %h %h %h", kind, fetch_addr, trace_alu,
                                            trace_word) == 4) begin
            drive_noise(1'b0);
            im_read_addr <= fetch_addr;
            // Looked up at edge E+2 by read thread (E+1) mod 4
            thread  = (cycle_index + 1) % thread_count;
            word    = im_model[fetch_addr];
            control = od_model[thread * od_thread_depth + int'(word[word_width-1 -: opcode_width])];
            if (word !== trace_word || control !== trace_alu) begin
                $display("Trace expects word %h and control %h at cycle %0d, model has %h and %h",
                         trace_word, trace_alu, cycle_index, word, control);
                stop_with_failure();
            end
            pending_valid.push_back(1'b1);
        end else if (kind == "i") begin
            drive_noise(1'b1);
            pending_valid.push_back(1'b0);
        end else begin
            $display("Malformed trace line at cycle %0d: %s", cycle_index, text);
            stop_with_failure();
        end
        pending_alu.push_back(control);
        pending_word.push_back(word);
    endtask

    task automatic compare_oldest();
        bit valid;
        alu_ctrl_t control;
        logic [word_width-1:0] word;
        logic [d_operand_width-1:0] d;
        if (pending_valid.size() < 3) return;
        valid   = pending_valid.pop_front();
        control = pending_alu.pop_front();
        word    = pending_word.pop_front();
        d       = word[word_width-opcode_width-1 -: d_operand_width];
        if (valid) begin
            check_alu(control, alu_control);
            check_d("da", d, da);
            check_d("db", rebase_d(d), db);
            check_a(word[a_operand_width+b_operand_width-1 -: a_operand_width], a);
            check_b(word[b_operand_width-1:0], b);
        end
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        int    found;
        string text;
        lfsr_state = 32'h40502a9e;
        {arst_n, ior_previous, cancel_previous} = 3'b000;
        {im_write_addr, im_write_data, im_read_addr} = '0;
        {od_write_addr, od_write_data} = '0;
        cycle_index = 0;
        trace_fd = $fopen(trace_path, "r");
        if (trace_fd == 0) begin
            $display("Cannot open the trace file %s", trace_path);
            stop_with_failure();
        end
        read_command(trace_fd, found, text);
        while (found) begin
            trace_total = trace_total + 1;
            read_command(trace_fd, found, text);
        end
        $fclose(trace_fd);
        trace_fd = $fopen(trace_path, "r");
        repeat (8) @(posedge clock);
        arst_n <= 1'b1;
        @(negedge clock);
        check_alu('0, alu_control);
        check_d("da", '0, da);
        check_d("db", '0, db);
        check_a('0, a);
        check_b('0, b);
        read_command(trace_fd, found, text);
        while (found) begin
            @(posedge clock);
            cycle_index = cycle_index + 1;
            run_command(text);
            @(negedge clock);
            compare_oldest();
            read_command(trace_fd, found, text);
        end
        // Two idle cycles at the end drain the fetches still in flight
        repeat (2) begin
            @(posedge clock);
            cycle_index = cycle_index + 1;
            run_command("i");
            @(negedge clock);
            compare_oldest();
        end
        $fclose(trace_fd);
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
hdl/ifd_pkg.sv
hdl/write_window_decoder.sv
hdl/instruction_memory.sv
hdl/opcode_decoder_memory.sv
hdl/instruction_fetch_decode.sv
hdl/instruction_fetch_decode_mapped.sv
tests/ifd_asserts.sv
tests/ifd_tb.sv

// File: tests/ifd_trace.txt
# One line per clock cycle after reset, all values hex
# w ior cancel im_addr im_data od_addr od_data | f read_addr alu_control word | i idle
w 1 0 200 1a2b3c4d5 000 000000000
w 1 0 201 2fedcba98 000 000000000
w 1 0 2ff e00000fff 000 000000000
w 1 0 210 140112233 000 000000000
w 1 0 000 000000000 301 000021111
w 1 0 000 000000000 301 000031111
w 1 0 000 000000000 301 000001111
w 1 0 000 000000000 301 000011111
w 1 0 000 000000000 302 000022222
w 1 0 000 000000000 30e 00003eeee
w 1 0 1ff 9ffffffff 300 00000aaaa
w 0 1 210 9bbbbbbbb 301 0000fffff
w 0 0 200 9dddddddd 301 0000fffff
w 1 1 201 9cccccccc 30e 0000fffff
w 1 0 300 9eeeeeeee 310 000055555
f 00 11111 1a2b3c4d5
f 00 21111 1a2b3c4d5
f 00 31111 1a2b3c4d5
f 00 01111 1a2b3c4d5
f 10 11111 140112233
f 01 22222 2fedcba98
f ff 3eeee e00000fff
w 1 0 220 0ff00ff00 000 000000000
i
i
i
f 20 0aaaa 0ff00ff00
w 1 0 000 000000000 301 000077777
f 00 21111 1a2b3c4d5
f 00 31111 1a2b3c4d5
f 00 01111 1a2b3c4d5
f 00 77777 1a2b3c4d5
w 1 0 201 1abcdef01 000 000000000
f 01 31111 1abcdef01
i
i
